//--- fpu_subsystem.f
common/fpu_pkg.sv
source/fpu_cmd_fifo.sv
source/f_register_file.sv
fpu/fpu_issue.sv
fpu/fpu_addsub.sv
fpu/fpu_mul.sv
fpu/fpu_core.sv
source/fpu_subsystem.sv
verif/tb_fpu_subsystem.sv

//--- verif/tb_fpu_subsystem.sv
// self-checking testbench for the FPU subsystem
// bit-exact float reference, expected writeback queue and a compare process
`timescale 1ns/100ps
`default_nettype none

module tb_fpu_subsystem;
	import fpu_pkg::*;

	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] SEED = 32'h0640_2f35;

	logic clk;
	logic nrst;
	logic cmd_valid;
	fpu_cmd_t cmd;
	logic cmd_ready;
	logic wb_valid;
	fpu_wb_t wb;
	fpu_flags_t fflags;

	logic [31:0] shadow [NREG];
	fpu_wb_t exp_q [$];
	fpu_wb_t exp_wb;
	logic [4:0] exp_flags;
	logic [31:0] lfsr;
	int errors;
	int err0;
	int cycles;
	int sent_count;
	int wb_count;
	int full_seen;
	int n_ok;
	int n_bad;
	int t_rd;
	int t_a;
	int t_b;

	fpu_subsystem u_dut (
		.clk       (clk),
		.nrst      (nrst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.fflags    (fflags)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// normal float with biased exponent in [ebase, ebase + span)
	function automatic logic [31:0] rand_float(input int ebase, input int span);
		logic s;
		logic [7:0] e;
		logic [22:0] f;
		s = rand_bits(1) != 0;
		e = 8'(ebase + int'(rand_bits(8)) % span);
		f = 23'(rand_bits(23));
		return {s, e, f};
	endfunction

	// rounds mag times 2^(msb + scale) to nearest-even and flushes underflow to zero
	function automatic logic [36:0] round_pack(input logic sign, input logic [299:0] mag,
			input int scale);
		int p;
		int e;
		logic [299:0] rem;
		logic [299:0] half;
		logic [24:0] m;
		logic up;
		p = 0;
		for (int i = 0; i < 300; i++) begin
			if (mag[i])
				p = i;
		end
		if (p >= 23) begin
			m   = 25'(mag >> (p - 23));
			rem = mag & ~({300{1'b1}} << (p - 23));
		end else begin
			m   = 25'(mag << (23 - p));
			rem = '0;
		end
		half = '0;
		up = 1'b0;
		if (p >= 24) begin
			half[p - 24] = 1'b1;
			up = (rem > half) || ((rem == half) && m[0]);
		end
		m = m + 25'(up);
		e = p + scale;
		if (m[24]) begin
			m = m >> 1;
			e = e + 1;
		end
		if (e >= 255)
			return {5'b00101, sign, 8'hff, 23'd0};
		if (e <= 0)
			return {5'b00011, sign, 31'd0};
		return {4'b0000, |rem, sign, 8'(e), m[22:0]};
	endfunction

	// {flags, data} for fadd, fsub and fmul
	function automatic logic [36:0] ref_fp(input fpu_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic sa, sb, sr;
		logic [7:0] ea;
		logic [7:0] eb;
		logic a_nan, b_nan, a_inf, b_inf, snan;
		logic [299:0] x;
		logic [299:0] y;
		logic [299:0] mag;
		int emin;
		sa = a[31];
		sb = b[31] ^ (op == OP_FSUB);
		ea = a[30:23];
		eb = b[30:23];
		a_nan = (ea == 8'hff) && (a[22:0] != 0);
		b_nan = (eb == 8'hff) && (b[22:0] != 0);
		a_inf = (ea == 8'hff) && (a[22:0] == 0);
		b_inf = (eb == 8'hff) && (b[22:0] == 0);
		snan = (a_nan && !a[22]) || (b_nan && !b[22]);
		// subnormals read as zero
		x = '0;
		y = '0;
		if (ea != 0)
			x[23:0] = {1'b1, a[22:0]};
		if (eb != 0)
			y[23:0] = {1'b1, b[22:0]};
		if (a_nan || b_nan)
			return {snan, 4'b0000, CANON_NAN};
		if (op == OP_FMUL) begin
			sr = sa ^ sb;
			if ((a_inf && eb == 0) || (b_inf && ea == 0))
				return {5'b10000, CANON_NAN};
			if (a_inf || b_inf)
				return {5'b00000, sr, 8'hff, 23'd0};
			if (ea == 0 || eb == 0)
				return {5'b00000, sr, 31'd0};
			mag = x * y;
			return round_pack(sr, mag, int'(ea) + int'(eb) - 173);
		end
		if (a_inf && b_inf && (sa != sb))
			return {5'b10000, CANON_NAN};
		if (a_inf)
			return {5'b00000, sa, 8'hff, 23'd0};
		if (b_inf)
			return {5'b00000, sb, 8'hff, 23'd0};
		// line both up on the smaller exponent and take an exact integer sum
		emin = (ea < eb) ? int'(ea) : int'(eb);
		x = x << (int'(ea) - emin);
		y = y << (int'(eb) - emin);
		if (sa == sb) begin
			mag = x + y;
			sr  = sa;
		end else if (x >= y) begin
			mag = x - y;
			sr  = sa;
		end else begin
			mag = y - x;
			sr  = sb;
		end
		if (mag == 0)
			return {5'b00000, sa & sb, 31'd0};
		return round_pack(sr, mag, emin - 23);
	endfunction

	// expected writeback computed in program order at acceptance
	task automatic record_cmd(input fpu_cmd_t c);
		logic [36:0] r;
		fpu_wb_t w;
		if (c.op == OP_FLW)
			r = {5'b00000, c.load_data};
		else
			r = ref_fp(c.op, shadow[c.rs1], shadow[c.rs2]);
		w.rd    = c.rd;
		w.data  = r[31:0];
		w.flags = r[36:32];
		shadow[c.rd] = r[31:0];
		exp_flags = exp_flags | r[36:32];
		exp_q.push_back(w);
		sent_count++;
	endtask

	// starts at posedge + 2 ns and returns there after the accepting edge
	task automatic send_cmd(input fpu_op_e op, input int rd, input int rs1, input int rs2,
			input logic [31:0] load);
		fpu_cmd_t c;
		logic rdy;
		c.op        = op;
		c.rd        = 5'(rd);
		c.rs1       = 5'(rs1);
		c.rs2       = 5'(rs2);
		c.load_data = load;
		cmd = c;
		cmd_valid = 1'b1;
		rdy = 1'b0;
		while (!rdy) begin
			@(negedge clk);
			rdy = cmd_ready;
			if (!rdy)
				full_seen++;
			@(posedge clk);
			#2;
		end
		record_cmd(c);
	endtask

	task automatic finish_case(input string name, input int first_err);
		cmd_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#2;
		if (fflags !== exp_flags) begin
			errors++;
			$display("FAIL fflags expected %h got %h", exp_flags, fflags);
		end
		if (wb_count != sent_count) begin
			errors++;
			$display("%0d commands accepted but %0d writebacks seen", sent_count, wb_count);
		end
		if (errors == first_err) begin
			n_ok++;
			$display("case %s: ok", name);
		end else begin
			n_bad++;
			$display("case %s: %0d errors", name, errors - first_err);
		end
	endtask

	// scoreboard compare in the middle of the cycle
	always @(negedge clk) begin
		if (nrst && wb_valid) begin
			wb_count++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("writeback to f%0d arrived with nothing outstanding", wb.rd);
			end else begin
				exp_wb = exp_q.pop_front();
				if (wb.rd !== exp_wb.rd) begin
					errors++;
					$display("FAIL wb.rd expected %h got %h", exp_wb.rd, wb.rd);
				end
				if (wb.data !== exp_wb.data) begin
					errors++;
					$display("FAIL wb.data expected %h got %h", exp_wb.data, wb.data);
				end
				if (wb.flags !== exp_wb.flags) begin
					errors++;
					$display("FAIL wb.flags expected %h got %h", exp_wb.flags, wb.flags);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		nrst = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		lfsr = SEED;
		exp_flags = '0;
		errors = 0;
		cycles = 0;
		sent_count = 0;
		wb_count = 0;
		full_seen = 0;
		n_ok = 0;
		n_bad = 0;
		for (int i = 0; i < NREG; i++)
			shadow[i] = '0;
		repeat (8) @(posedge clk);
		#2;
		nrst = 1'b1;

		err0 = errors;
		if (cmd_ready !== 1'b1) begin
			errors++;
			$display("FAIL cmd_ready expected %h got %h", 1'b1, cmd_ready);
		end
		if (wb_valid !== 1'b0) begin
			errors++;
			$display("FAIL wb_valid expected %h got %h", 1'b0, wb_valid);
		end
		if (fflags !== 5'b00000) begin
			errors++;
			$display("FAIL fflags expected %h got %h", 5'h00, fflags);
		end
		for (int i = 0; i < 8; i++)
			send_cmd(OP_FLW, 1 + 3 * i, 0, 0, rand_bits(32));
		finish_case("flw load data", err0);

		err0 = errors;
		for (int i = 1; i <= 8; i++)
			send_cmd(OP_FLW, i, 0, 0, rand_float(124, 8));
		for (int i = 0; i < 24; i++) begin
			t_rd = 16 + int'(rand_bits(4));
			t_a  = 1 + int'(rand_bits(3));
			t_b  = 1 + int'(rand_bits(3));
			send_cmd((rand_bits(1) != 0) ? OP_FSUB : OP_FADD, t_rd, t_a, t_b, '0);
		end
		finish_case("fadd/fsub random", err0);

		err0 = errors;
		for (int i = 1; i <= 8; i++)
			send_cmd(OP_FLW, i, 0, 0, rand_float(1, 254));
		// 2^100 and 2^-100 force overflow and underflow
		send_cmd(OP_FLW, 9, 0, 0, 32'h7180_0000);
		send_cmd(OP_FLW, 10, 0, 0, 32'h0d80_0000);
		send_cmd(OP_FMUL, 11, 9, 9, '0);
		send_cmd(OP_FMUL, 12, 10, 10, '0);
		send_cmd(OP_FMUL, 13, 9, 10, '0);
		for (int i = 0; i < 24; i++) begin
			t_rd = 16 + int'(rand_bits(4));
			t_a  = 1 + int'(rand_bits(3));
			t_b  = 1 + int'(rand_bits(3));
			send_cmd(OP_FMUL, t_rd, t_a, t_b, '0);
		end
		finish_case("fmul random", err0);

		err0 = errors;
		send_cmd(OP_FLW, 1, 0, 0, 32'h7f80_0000);
		send_cmd(OP_FLW, 2, 0, 0, 32'hff80_0000);
		send_cmd(OP_FLW, 3, 0, 0, 32'h0000_0000);
		send_cmd(OP_FLW, 4, 0, 0, 32'h7fc1_2345);
		send_cmd(OP_FLW, 5, 0, 0, 32'h7f81_2345);
		send_cmd(OP_FLW, 6, 0, 0, 32'h3f80_0000);
		send_cmd(OP_FLW, 7, 0, 0, 32'h8000_0000);
		send_cmd(OP_FSUB, 10, 1, 1, '0);
		send_cmd(OP_FADD, 11, 1, 2, '0);
		send_cmd(OP_FMUL, 12, 3, 1, '0);
		send_cmd(OP_FMUL, 13, 2, 7, '0);
		send_cmd(OP_FADD, 14, 4, 6, '0);
		send_cmd(OP_FMUL, 15, 5, 6, '0);
		send_cmd(OP_FADD, 16, 1, 6, '0);
		send_cmd(OP_FADD, 17, 7, 7, '0);
		send_cmd(OP_FSUB, 18, 3, 3, '0);
		send_cmd(OP_FMUL, 19, 6, 3, '0);
		finish_case("special values", err0);

		err0 = errors;
		send_cmd(OP_FLW, 1, 0, 0, 32'h3fc0_0000);
		send_cmd(OP_FLW, 2, 0, 0, 32'h4020_0000);
		send_cmd(OP_FADD, 3, 1, 2, '0);
		send_cmd(OP_FMUL, 4, 3, 3, '0);
		send_cmd(OP_FSUB, 3, 4, 1, '0);
		send_cmd(OP_FADD, 5, 3, 4, '0);
		send_cmd(OP_FMUL, 1, 5, 3, '0);
		send_cmd(OP_FADD, 2, 1, 1, '0);
		send_cmd(OP_FSUB, 6, 2, 5, '0);
		for (int i = 0; i < 8; i++) begin
			t_a = 1 + int'(rand_bits(2));
			send_cmd((rand_bits(1) != 0) ? OP_FMUL : OP_FADD, 7, 7, t_a, '0);
		end
		finish_case("dependent chain", err0);

		err0 = errors;
		full_seen = 0;
		send_cmd(OP_FLW, 20, 0, 0, 32'h3f80_0000);
		send_cmd(OP_FLW, 21, 0, 0, rand_float(120, 8));
		// each add waits on the one before so the queue backs up
		for (int i = 0; i < 16; i++)
			send_cmd(OP_FADD, 20, 20, 21, '0);
		for (int i = 0; i < 8; i++)
			send_cmd(OP_FLW, 22 + i, 0, 0, rand_bits(32));
		if (full_seen == 0) begin
			errors++;
			$display("cmd_ready never dropped during the burst");
		end
		finish_case("queue burst", err0);

		$display("cases: %0d ok, %0d failed, %0d errors", n_ok, n_bad, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/fpu_subsystem.sv
// fpu_subsystem: command FIFO, issue stage, FPU core and float register file
`timescale 1ns/100ps
`default_nettype none

module fpu_subsystem (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  cmd_valid,
	input  fpu_pkg::fpu_cmd_t     cmd,
	output logic                  cmd_ready,
	output logic                  wb_valid,
	output fpu_pkg::fpu_wb_t      wb,
	output fpu_pkg::fpu_flags_t   fflags
);
	import fpu_pkg::*;

	logic q_valid;
	logic q_pop;
	fpu_cmd_t q_cmd;
	logic [RADDR_W-1:0] rs1;
	logic [RADDR_W-1:0] rs2;
	logic [FLEN-1:0] rs1_data;
	logic [FLEN-1:0] rs2_data;
	logic s1_valid;
	logic [RADDR_W-1:0] s1_rd;
	logic issue_valid;
	fpu_issue_t issue;

	fpu_cmd_fifo u_fifo (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (cmd_valid),
		.in_cmd    (cmd),
		.in_ready  (cmd_ready),
		.out_valid (q_valid),
		.out_cmd   (q_cmd),
		.pop       (q_pop)
	);

	fpu_issue u_issue (
		.clk         (clk),
		.nrst        (nrst),
		.q_valid     (q_valid),
		.q_cmd       (q_cmd),
		.pop         (q_pop),
		.rs1         (rs1),
		.rs2         (rs2),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.s1_valid    (s1_valid),
		.s1_rd       (s1_rd),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	fpu_core u_core (
		.clk         (clk),
		.nrst        (nrst),
		.issue_valid (issue_valid),
		.issue       (issue),
		.s1_valid    (s1_valid),
		.s1_rd       (s1_rd),
		.wb_valid    (wb_valid),
		.wb          (wb)
	);

	f_register_file u_regs (
		.clk      (clk),
		.nrst     (nrst),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb       (wb),
		.fflags   (fflags)
	);

endmodule

`default_nettype wire

//--- fpu/fpu_core.sv
// two-stage FPU core around the add/sub and multiply units
// stage 2 picks the unit result or the load data for writeback
`timescale 1ns/100ps
`default_nettype none

module fpu_core (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          issue_valid,
	input  fpu_pkg::fpu_issue_t           issue,
	output logic                          s1_valid,
	output logic [fpu_pkg::RADDR_W-1:0]   s1_rd,
	output logic                          wb_valid,
	output fpu_pkg::fpu_wb_t              wb
);
	import fpu_pkg::*;

	fpu_op_e s1_op;
	fpu_op_e s2_op;
	logic [FLEN-1:0] s1_load;
	logic [FLEN-1:0] s2_load;
	logic [RADDR_W-1:0] s2_rd;
	logic add_valid;
	logic mul_valid;
	logic [FLEN-1:0] add_res;
	logic [FLEN-1:0] mul_res;
	fpu_flags_t add_flags;
	fpu_flags_t mul_flags;

	assign add_valid = issue_valid && ((issue.op == OP_FADD) || (issue.op == OP_FSUB));
	assign mul_valid = issue_valid && (issue.op == OP_FMUL);

	fpu_addsub u_addsub (
		.clk      (clk),
		.nrst     (nrst),
		.in_valid (add_valid),
		.a        (issue.a),
		.b        (issue.b),
		.sub      (issue.op == OP_FSUB),
		.res      (add_res),
		.flags    (add_flags)
	);

	fpu_mul u_mul (
		.clk      (clk),
		.nrst     (nrst),
		.in_valid (mul_valid),
		.a        (issue.a),
		.b        (issue.b),
		.res      (mul_res),
		.flags    (mul_flags)
	);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			s1_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
			wb_valid <= s1_valid;
		end
	end

	// op, rd and load data ride alongside the units
	always_ff @(posedge clk) begin
		s1_op   <= issue.op;
		s1_rd   <= issue.rd;
		s1_load <= issue.load_data;
		s2_op   <= s1_op;
		s2_rd   <= s1_rd;
		s2_load <= s1_load;
	end

	// load data or fpu result into the register file
	always_comb begin
		wb.rd = s2_rd;
		case (s2_op)
			OP_FLW: begin
				wb.data  = s2_load;
				wb.flags = '0;
			end
			OP_FMUL: begin
				wb.data  = mul_res;
				wb.flags = mul_flags;
			end
			default: begin
				wb.data  = add_res;
				wb.flags = add_flags;
			end
		endcase
	end

	a_legal_op: assert property (@(posedge clk) disable iff (!nrst)
		issue_valid |-> (!$isunknown(issue.op) &&
			(issue.op inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FLW})));

endmodule

`default_nettype wire

//--- fpu/fpu_mul.sv
// fpu_mul: two-stage single-precision multiply, RNE only
// stage 1 forms the 48-bit product, stage 2 normalizes and rounds
`timescale 1ns/100ps
`default_nettype none

module fpu_mul (
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       in_valid,
	input  logic [fpu_pkg::FLEN-1:0]   a,
	input  logic [fpu_pkg::FLEN-1:0]   b,
	output logic [fpu_pkg::FLEN-1:0]   res,
	output fpu_pkg::fpu_flags_t        flags
);
	import fpu_pkg::*;

	logic sign;
	logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, a_snan, b_snan;
	logic spec, spec_nv;
	logic [FLEN-1:0] spec_res;
	logic s1_v, r_spec, r_spec_nv, r_sign;
	logic [FLEN-1:0] r_spec_res;
	logic signed [9:0] r_exp, exp_n, exp_r;
	logic [47:0] r_prod;
	logic [23:0] man;
	logic g, st, rnd_up;
	logic [24:0] man_r;
	logic [FLEN-1:0] res_d;
	fpu_flags_t fl_d;

	assign sign   = a[31] ^ b[31];
	assign a_zero = (a[30:23] == 8'd0);
	assign b_zero = (b[30:23] == 8'd0);
	assign a_nan  = (&a[30:23]) && (|a[22:0]);
	assign b_nan  = (&b[30:23]) && (|b[22:0]);
	assign a_inf  = (&a[30:23]) && !(|a[22:0]);
	assign b_inf  = (&b[30:23]) && !(|b[22:0]);
	assign a_snan = a_nan && !a[22];
	assign b_snan = b_nan && !b[22];

	always_comb begin
		spec     = 1'b1;
		spec_nv  = 1'b0;
		spec_res = CANON_NAN;
		if (a_nan || b_nan)
			spec_nv = a_snan || b_snan;
		else if ((a_inf && b_zero) || (b_inf && a_zero))
			spec_nv = 1'b1;
		else if (a_inf || b_inf)
			spec_res = {sign, 8'hff, 23'd0};
		else if (a_zero || b_zero)
			spec_res = {sign, 31'd0};
		else
			spec = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			s1_v <= 1'b0;
		else
			s1_v <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			r_spec     <= spec;
			r_spec_nv  <= spec_nv;
			r_spec_res <= spec_res;
			r_sign     <= sign;
			r_exp      <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;
			r_prod     <= {1'b1, a[22:0]} * {1'b1, b[22:0]};
		end
	end

	// product is in [1,4), one step right at most
	always_comb begin
		if (r_prod[47]) begin
			man   = r_prod[47:24];
			g     = r_prod[23];
			st    = |r_prod[22:0];
			exp_n = r_exp + 10'sd1;
		end else begin
			man   = r_prod[46:23];
			g     = r_prod[22];
			st    = |r_prod[21:0];
			exp_n = r_exp;
		end
		rnd_up = g & (st | man[0]);
		man_r  = {1'b0, man} + {24'd0, rnd_up};
		exp_r  = exp_n + $signed({9'd0, man_r[24]});
		fl_d   = '0;
		if (r_spec) begin
			res_d   = r_spec_res;
			fl_d.nv = r_spec_nv;
		end else if (exp_r >= 10'sd255) begin
			res_d   = {r_sign, 8'hff, 23'd0};
			fl_d.of = 1'b1;
			fl_d.nx = 1'b1;
		end else if (exp_r <= 10'sd0) begin
			res_d   = {r_sign, 31'd0};
			fl_d.uf = 1'b1;
			fl_d.nx = 1'b1;
		end else begin
			res_d   = {r_sign, exp_r[7:0], man_r[24] ? 23'd0 : man_r[22:0]};
			fl_d.nx = g | st;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_v) begin
			res   <= res_d;
			flags <= fl_d;
		end
	end

endmodule

`default_nettype wire

//--- fpu/fpu_addsub.sv
// fpu_addsub: two-stage single-precision add/subtract, RNE only
// stage 1 unpacks and aligns, stage 2 adds, normalizes and rounds
`timescale 1ns/100ps
`default_nettype none

module fpu_addsub (
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       in_valid,
	input  logic [fpu_pkg::FLEN-1:0]   a,
	input  logic [fpu_pkg::FLEN-1:0]   b,
	input  logic                       sub,
	output logic [fpu_pkg::FLEN-1:0]   res,
	output fpu_pkg::fpu_flags_t        flags
);
	import fpu_pkg::*;

	logic sb;
	logic a_nan, b_nan, a_inf, b_inf, a_snan, b_snan;
	logic a_big;
	logic [7:0] ea, eb, e_big, e_sml, d;
	logic [4:0] dcap;
	logic [23:0] ma, mb, m_big, m_sml;
	logic [53:0] shf;
	logic spec, spec_nv;
	logic [FLEN-1:0] spec_res;
	// stage 1 registers
	logic s1_v, r_spec, r_spec_nv, r_sign, r_zsign, r_sub;
	logic [FLEN-1:0] r_spec_res;
	logic [7:0] r_exp;
	logic [26:0] r_mbig, r_msml;
	// stage 2 datapath
	logic [27:0] sum;
	logic [4:0] lz;
	logic [26:0] norm;
	logic signed [9:0] exp_n, exp_r;
	logic rnd_up;
	logic [24:0] man_r;
	logic [FLEN-1:0] res_d;
	fpu_flags_t fl_d;

	// subnormals flush to zero here
	assign ea     = a[30:23];
	assign eb     = b[30:23];
	assign ma     = (ea == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
	assign mb     = (eb == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
	assign sb     = b[31] ^ sub;
	assign a_nan  = (&ea) && (|a[22:0]);
	assign b_nan  = (&eb) && (|b[22:0]);
	assign a_inf  = (&ea) && !(|a[22:0]);
	assign b_inf  = (&eb) && !(|b[22:0]);
	assign a_snan = a_nan && !a[22];
	assign b_snan = b_nan && !b[22];

	assign a_big = ({ea, ma} >= {eb, mb});
	assign e_big = a_big ? ea : eb;
	assign e_sml = a_big ? eb : ea;
	assign m_big = a_big ? ma : mb;
	assign m_sml = a_big ? mb : ma;
	assign d     = e_big - e_sml;
	assign dcap  = (d > 8'd27) ? 5'd27 : d[4:0];
	// bits shifted past the round position collapse into sticky
	assign shf   = {m_sml, 3'b000, 27'd0} >> dcap;

	always_comb begin
		spec     = 1'b1;
		spec_nv  = 1'b0;
		spec_res = CANON_NAN;
		if (a_nan || b_nan)
			spec_nv = a_snan || b_snan;
		else if (a_inf && b_inf && (a[31] != sb))
			spec_nv = 1'b1;
		else if (a_inf)
			spec_res = {a[31], 8'hff, 23'd0};
		else if (b_inf)
			spec_res = {sb, 8'hff, 23'd0};
		else
			spec = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			s1_v <= 1'b0;
		else
			s1_v <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			r_spec     <= spec;
			r_spec_nv  <= spec_nv;
			r_spec_res <= spec_res;
			r_sign     <= a_big ? a[31] : sb;
			r_zsign    <= a[31] & sb;
			r_sub      <= (a[31] != sb);
			r_exp      <= e_big;
			r_mbig     <= {m_big, 3'b000};
			r_msml     <= {shf[53:28], shf[27] | (|shf[26:0])};
		end
	end

	assign sum = r_sub ? ({1'b0, r_mbig} - {1'b0, r_msml}) : ({1'b0, r_mbig} + {1'b0, r_msml});

	// leading zeros above bit 26, used after a cancellation
	always_comb begin
		lz = 5'd0;
		for (int i = 0; i < 27; i++) begin
			if (sum[i])
				lz = 5'(26 - i);
		end
	end

	always_comb begin
		if (sum[27]) begin
			norm  = {sum[27:2], sum[1] | sum[0]};
			exp_n = $signed({2'b00, r_exp}) + 10'sd1;
		end else begin
			norm  = sum[26:0] << lz;
			exp_n = $signed({2'b00, r_exp}) - $signed({5'd0, lz});
		end
		rnd_up = norm[2] & (norm[1] | norm[0] | norm[3]);
		man_r  = {1'b0, norm[26:3]} + {24'd0, rnd_up};
		exp_r  = exp_n + $signed({9'd0, man_r[24]});
		fl_d   = '0;
		if (r_spec) begin
			res_d   = r_spec_res;
			fl_d.nv = r_spec_nv;
		end else if (sum == 28'd0) begin
			res_d = {r_zsign, 31'd0};
		end else if (exp_r >= 10'sd255) begin
			res_d   = {r_sign, 8'hff, 23'd0};
			fl_d.of = 1'b1;
			fl_d.nx = 1'b1;
		end else if (exp_r <= 10'sd0) begin
			res_d   = {r_sign, 31'd0};
			fl_d.uf = 1'b1;
			fl_d.nx = 1'b1;
		end else begin
			res_d   = {r_sign, exp_r[7:0], man_r[24] ? 23'd0 : man_r[22:0]};
			fl_d.nx = |norm[2:0];
		end
	end

	always_ff @(posedge clk) begin
		if (s1_v) begin
			res   <= res_d;
			flags <= fl_d;
		end
	end

endmodule

`default_nettype wire

//--- fpu/fpu_issue.sv
// fpu_issue: pops queued commands, stalls on RAW hazards,
// reads both operands and launches the op into the core
`timescale 1ns/100ps
`default_nettype none

module fpu_issue (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic                          q_valid,
	input  fpu_pkg::fpu_cmd_t             q_cmd,
	output logic                          pop,
	output logic [fpu_pkg::RADDR_W-1:0]   rs1,
	output logic [fpu_pkg::RADDR_W-1:0]   rs2,
	input  logic [fpu_pkg::FLEN-1:0]      rs1_data,
	input  logic [fpu_pkg::FLEN-1:0]      rs2_data,
	input  logic                          s1_valid,
	input  logic [fpu_pkg::RADDR_W-1:0]   s1_rd,
	output logic                          issue_valid,
	output fpu_pkg::fpu_issue_t           issue
);
	import fpu_pkg::*;

	logic uses_src;
	logic hit_issue;
	logic hit_s1;
	logic hazard;

	assign rs1 = q_cmd.rs1;
	assign rs2 = q_cmd.rs2;

	// flw carries its own data
	assign uses_src = (q_cmd.op != OP_FLW);

	// stage 2 of the core is handled by the register file bypass
	assign hit_issue = issue_valid && ((issue.rd == rs1) || (issue.rd == rs2));
	assign hit_s1    = s1_valid && ((s1_rd == rs1) || (s1_rd == rs2));
	assign hazard    = uses_src && (hit_issue || hit_s1);

	assign pop = q_valid && !hazard;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			issue.op        <= q_cmd.op;
			issue.rd        <= q_cmd.rd;
			issue.a         <= rs1_data;
			issue.b         <= rs2_data;
			issue.load_data <= q_cmd.load_data;
		end
	end

endmodule

`default_nettype wire

//--- source/f_register_file.sv
// f_register_file: 32 float registers with two write-through read ports
// also keeps the sticky fflags register
`timescale 1ns/100ps
`default_nettype none

module f_register_file (
	input  logic                          clk,
	input  logic                          nrst,
	input  logic [fpu_pkg::RADDR_W-1:0]   rs1,
	input  logic [fpu_pkg::RADDR_W-1:0]   rs2,
	output logic [fpu_pkg::FLEN-1:0]      rs1_data,
	output logic [fpu_pkg::FLEN-1:0]      rs2_data,
	input  logic                          wb_valid,
	input  fpu_pkg::fpu_wb_t              wb,
	output fpu_pkg::fpu_flags_t           fflags
);
	import fpu_pkg::*;

	logic [FLEN-1:0] regs [NREG];
	logic hit1;
	logic hit2;

	// a same-cycle writeback wins over the stored value
	assign hit1 = wb_valid && (wb.rd == rs1);
	assign hit2 = wb_valid && (wb.rd == rs2);

	always_comb begin
		if (hit1)
			rs1_data = wb.data;
		else
			rs1_data = regs[rs1];
	end

	always_comb begin
		if (hit2)
			rs2_data = wb.data;
		else
			rs2_data = regs[rs2];
	end

	// all registers come out of reset as +0
	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// flags accumulate until the next reset
	always_ff @(posedge clk) begin
		if (!nrst) begin
			fflags <= '0;
		end else if (wb_valid) begin
			fflags <= fpu_flags_t'(fflags | wb.flags);
		end
	end

endmodule

`default_nettype wire

//--- source/fpu_cmd_fifo.sv
// fpu_cmd_fifo: four-entry circular command queue
// valid/ready on the write side, valid/pop on the read side
`timescale 1ns/100ps
`default_nettype none

module fpu_cmd_fifo (
	input  logic                clk,
	input  logic                nrst,
	input  logic                in_valid,
	input  fpu_pkg::fpu_cmd_t   in_cmd,
	output logic                in_ready,
	output logic                out_valid,
	output fpu_pkg::fpu_cmd_t   out_cmd,
	input  logic                pop
);
	import fpu_pkg::*;

	fpu_cmd_t mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic push;
	logic take;

	assign in_ready  = (count != FIFO_DEPTH);
	assign out_valid = (count != 0);
	assign out_cmd   = mem[rd_ptr];
	assign push      = in_valid & in_ready;
	assign take      = pop & out_valid;

	// storage, no reset needed
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (take)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// sender keeps the command steady while the queue is full
	a_hold_while_full: assert property (@(posedge clk) disable iff (!nrst)
		(in_valid && !in_ready) |=> (in_valid && $stable(in_cmd)));

	// issue stage must never pop an empty queue
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
		pop |-> out_valid);

endmodule

`default_nettype wire

//--- common/fpu_pkg.sv
// fpu_pkg: shared widths, opcodes and payload types
// for the single-precision FPU subsystem
`default_nettype none

package fpu_pkg;

	localparam int FLEN       = 32;
	localparam int NREG       = 32;
	localparam int RADDR_W    = $clog2(NREG);
	localparam int FIFO_DEPTH = 4;

	// quiet NaN returned by every invalid or NaN-fed op
	localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

	typedef enum logic [1:0] {
		OP_FADD = 2'b00,
		OP_FSUB = 2'b01,
		OP_FMUL = 2'b10,
		OP_FLW  = 2'b11
	} fpu_op_e;

	// command as it arrives on the external port
	typedef struct packed {
		fpu_op_e            op;
		logic [RADDR_W-1:0] rd;
		logic [RADDR_W-1:0] rs1;
		logic [RADDR_W-1:0] rs2;
		logic [FLEN-1:0]    load_data;
	} fpu_cmd_t;

	// nv in bit 4 down to nx in bit 0
	typedef struct packed {
		logic nv;
		logic dz;
		logic of;
		logic uf;
		logic nx;
	} fpu_flags_t;

	typedef struct packed {
		logic [RADDR_W-1:0] rd;
		logic [FLEN-1:0]    data;
		fpu_flags_t         flags;
	} fpu_wb_t;

	// operands already read out of the register file
	typedef struct packed {
		fpu_op_e            op;
		logic [RADDR_W-1:0] rd;
		logic [FLEN-1:0]    a;
		logic [FLEN-1:0]    b;
		logic [FLEN-1:0]    load_data;
	} fpu_issue_t;

endpackage

`default_nettype wire
